// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  - verilog/uart_rx_pkg.sv
  - verilog/uart_rx_sampler.sv
  - verilog/uart_rx_frame.sv
  - verilog/uart_rx_fifo.sv
  - verilog/uart_rx_out.sv
  - verilog/uart_rx.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/uart_rx_checker.sv
      - tests/tb_uart_rx.sv

// ==== sim.f ====
+incdir+tests
verilog/uart_rx_pkg.sv
verilog/uart_rx_sampler.sv
verilog/uart_rx_frame.sv
verilog/uart_rx_fifo.sv
verilog/uart_rx_out.sv
verilog/uart_rx.sv
tests/uart_rx_checker.sv
tests/tb_uart_rx.sv

// ==== tests/uart_rx_tb_table.svh ====
// Columns: data, cfg {word_len, par_en, par_mode, trig_level}, injected fault,
// expected character {par_err, frame_err, brk, data}

typedef enum logic [1:0] {
  FAULT_NONE,
  FAULT_PARITY,  // Parity bit inverted
  FAULT_STOP,    // Stop bit low
  FAULT_BREAK    // Whole frame low
} fault_e;

typedef struct packed {
  logic [7:0]            data;
  uart_rx_pkg::rx_cfg_t  cfg;
  fault_e                fault;
  uart_rx_pkg::rx_char_t exp;
} frame_row_t;

localparam int unsigned NR_ROWS       = 16;
localparam int unsigned BP_TRIG_CHARS = 8;  // TRIG_8 while ack is held low

localparam frame_row_t FRAME_TABLE [NR_ROWS] = '{
  '{8'hF5, 7'b00_0_00_00, FAULT_NONE,   {3'b000, 8'h15}},  // 5 bits, top dropped
  '{8'hAA, 7'b01_0_00_00, FAULT_NONE,   {3'b000, 8'h2A}},
  '{8'hC3, 7'b10_0_00_00, FAULT_NONE,   {3'b000, 8'h43}},
  '{8'h5A, 7'b11_0_00_00, FAULT_NONE,   {3'b000, 8'h5A}},
  '{8'h37, 7'b11_1_00_00, FAULT_NONE,   {3'b000, 8'h37}},  // Odd
  '{8'h37, 7'b11_1_00_00, FAULT_PARITY, {3'b100, 8'h37}},
  '{8'h81, 7'b11_1_01_00, FAULT_NONE,   {3'b000, 8'h81}},  // Even
  '{8'h6C, 7'b10_1_01_00, FAULT_PARITY, {3'b100, 8'h6C}},
  '{8'h00, 7'b11_1_10_00, FAULT_NONE,   {3'b000, 8'h00}},  // Forced 1, no break
  '{8'h15, 7'b01_1_10_00, FAULT_PARITY, {3'b100, 8'h15}},
  '{8'hE7, 7'b11_1_11_00, FAULT_NONE,   {3'b000, 8'hE7}},  // Forced 0
  '{8'h1F, 7'b00_1_11_00, FAULT_PARITY, {3'b100, 8'h1F}},
  '{8'h9C, 7'b11_0_00_00, FAULT_STOP,   {3'b010, 8'h9C}},
  '{8'h00, 7'b11_0_00_00, FAULT_BREAK,  {3'b011, 8'h00}},
  '{8'hA5, 7'b11_0_00_00, FAULT_NONE,   {3'b000, 8'hA5}},  // Clean after break
  '{8'h00, 7'b11_1_01_00, FAULT_BREAK,  {3'b011, 8'h00}}   // Even parity 0 is right
};

// ==== tests/tb_uart_rx.sv ====
`timescale 1ns/1ps

module tb_uart_rx;

  `include "uart_rx_tb_table.svh"

  localparam int unsigned OVERSAMPLE = 16;
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned TICK_DIV   = 4;                       // Clocks per tick
  localparam int unsigned BIT_CLKS   = OVERSAMPLE * TICK_DIV;
  localparam int unsigned IDLE_CLKS  = 2 * BIT_CLKS;            // Gap between frames
  localparam int unsigned WAIT_LIMIT = 4000;
  localparam logic [31:0] SEED       = 32'h9fdef8ec;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  tick;
  logic [1:0]            tick_cnt;
  logic                  rxd;
  uart_rx_pkg::rx_cfg_t  cfg;
  logic                  ack;
  logic                  ack_en;  // Low holds ack off
  logic                  req;
  logic                  trigger;
  logic                  overrun;
  uart_rx_pkg::rx_char_t rx_char;
  logic                  idle_check;
  logic                  trig_check;
  logic                  final_check;
  int unsigned           frames_sent;
  int unsigned           err_cnt;
  int unsigned           rx_cnt;
  logic                  ok;

  always #50 clk = !clk;

  // Oversample tick every TICK_DIV clocks
  always @(posedge clk) begin
    if (!rst_n) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick     <= (tick_cnt == 2'(TICK_DIV - 1));
    end
  end

  uart_rx #(
    .OVERSAMPLE (OVERSAMPLE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_uart_rx (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .oversample_tick_i (tick),
    .rxd_i             (rxd),
    .cfg_i             (cfg),
    .ack_i             (ack),
    .req_o             (req),
    .char_o            (rx_char),
    .trigger_o         (trigger),
    .overrun_o         (overrun)
  );

  uart_rx_checker #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_uart_rx_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_i         (req),
    .ack_i         (ack),
    .char_i        (rx_char),
    .trigger_i     (trigger),
    .overrun_i     (overrun),
    .idle_check_i  (idle_check),
    .trig_check_i  (trig_check),
    .frames_sent_i (frames_sent),
    .final_check_i (final_check),
    .err_cnt_o     (err_cnt),
    .rx_cnt_o      (rx_cnt)
  );

  // ----------------------------------------------------------------------
  // Serial line driver
  // ----------------------------------------------------------------------
  task automatic drive_bit(input logic value);
    rxd <= value;
    repeat (BIT_CLKS) @(posedge clk);
  endtask

  task automatic send_frame(input int unsigned idx, input logic back_pressure,
                            input int unsigned sent);
    frame_row_t           row;
    uart_rx_pkg::rx_cfg_t frame_cfg;
    int unsigned          nbits;
    logic                 par;
    logic                 brk;
    logic                 stop;
    row       = FRAME_TABLE[idx];
    frame_cfg = row.cfg;
    if (back_pressure) frame_cfg.trig_level = uart_rx_pkg::TRIG_8;
    nbits = 32'(row.cfg.word_len) + 5;
    brk   = (row.fault == FAULT_BREAK);
    par   = 1'b0;
    for (int b = 0; b < nbits; b++) par ^= row.data[b];  // Data parity
    case (row.cfg.par_mode)
      uart_rx_pkg::PAR_ODD:  par = !par;
      uart_rx_pkg::PAR_ONE:  par = 1'b1;
      uart_rx_pkg::PAR_ZERO: par = 1'b0;
      default:               par = par;  // Even keeps data parity
    endcase
    if (row.fault == FAULT_PARITY) par = !par;
    stop = (row.fault != FAULT_STOP) && !brk;
    cfg <= frame_cfg;  // Line idle here
    drive_bit(1'b0);   // Start
    for (int b = 0; b < nbits; b++) drive_bit(row.data[b] && !brk);  // LSB first
    if (row.cfg.par_en) drive_bit(par && !brk);
    drive_bit(stop);
    rxd         <= 1'b1;
    trig_check  <= back_pressure;  // Push done by now
    frames_sent <= sent;
    @(posedge clk);
    trig_check <= 1'b0;
    repeat (IDLE_CLKS - 1) @(posedge clk);
  endtask

  task automatic wait_chars(input int unsigned target, output logic done);
    int unsigned cycles;
    cycles = 0;
    while ((rx_cnt < target) && (cycles < WAIT_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    done = (rx_cnt >= target);
    if (!done) begin
      $display("Timeout after %0d cycles waiting for %0d characters, got %0d",
               cycles, target, rx_cnt);
    end
  endtask

  // ack follows req after 0 to 3 cycles
  initial begin
    int unsigned dly;
    void'($urandom(SEED));
    ack = 1'b0;
    dly = $urandom_range(3, 0);
    forever begin
      @(posedge clk);
      if (ack) begin
        if (!req) begin
          ack <= 1'b0;
          dly = $urandom_range(3, 0);
        end
      end else if (req && ack_en) begin
        if (dly == 0) ack <= 1'b1;
        else dly--;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n       = 1'b0;
    tick        = 1'b0;
    rxd         = 1'b1;
    cfg         = '0;
    ack_en      = 1'b0;
    idle_check  = 1'b0;
    trig_check  = 1'b0;
    final_check = 1'b0;
    frames_sent = 0;
    ok          = 1'b1;
    repeat (8) @(posedge clk);
    rst_n      <= 1'b1;
    idle_check <= 1'b1;  // Line stays high for the whole window
    repeat (4 * BIT_CLKS) @(posedge clk);
    idle_check <= 1'b0;
    ack_en     <= 1'b1;
    for (int i = 0; i < NR_ROWS; i++) send_frame(i, 1'b0, 0);
    wait_chars(NR_ROWS, ok);
    if (ok) begin
      ack_en <= 1'b0;  // FIFO fills and the last two frames overrun
      for (int k = 0; k < FIFO_DEPTH + 2; k++) send_frame(k % NR_ROWS, 1'b1, k + 1);
      ack_en <= 1'b1;
      wait_chars(NR_ROWS + FIFO_DEPTH, ok);
    end
    repeat (2 * BIT_CLKS) @(posedge clk);  // Room for stray characters
    final_check <= 1'b1;
    @(posedge clk);
    final_check <= 1'b0;
    repeat (2) @(posedge clk);
    $display("Errors: %0d, characters received: %0d", err_cnt, rx_cnt);
    if (ok && (err_cnt == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tests/uart_rx_checker.sv ====
`timescale 1ns/1ps

module uart_rx_checker #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  ack_i,
  input  uart_rx_pkg::rx_char_t char_i,
  input  logic                  trigger_i,
  input  logic                  overrun_i,
  input  logic                  idle_check_i,   // Outputs must be quiet
  input  logic                  trig_check_i,   // Compare trigger now
  input  int unsigned           frames_sent_i,
  input  logic                  final_check_i,
  output int unsigned           err_cnt_o,
  output int unsigned           rx_cnt_o
);

  `include "uart_rx_tb_table.svh"

  localparam int unsigned NR_EXPECTED = NR_ROWS + FIFO_DEPTH;  // Two frames lost
  localparam int unsigned NR_OVERRUNS = 2;

  int unsigned           err_cnt     = 0;
  int unsigned           rx_cnt      = 0;
  int unsigned           overrun_cnt = 0;
  logic                  req_q       = 1'b0;
  logic                  ack_q       = 1'b0;
  uart_rx_pkg::rx_char_t char_q      = '0;
  uart_rx_pkg::rx_char_t exp_char;

  task automatic log_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // ----------------------------------------------------------------------
  // Handshake and character compare
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (req_q && req_i && (char_i !== char_q)) begin
        log_error("char_o changed while req_o high");
      end
      if (!req_q && req_i && ack_q) begin
        log_error("req_o rose while ack_i still high");
      end
      if (req_i && ack_i) begin  // Accepted this edge
        exp_char = FRAME_TABLE[rx_cnt % NR_ROWS].exp;
        if (rx_cnt >= NR_EXPECTED) begin
          log_error($sformatf("extra character %03h", char_i));
        end else if (char_i !== exp_char) begin
          log_error($sformatf("character %0d is %03h, expected %03h",
                              rx_cnt, char_i, exp_char));
        end
        rx_cnt <= rx_cnt + 1;
      end
      if (overrun_i) overrun_cnt++;
      // Quiet line after reset
      if (idle_check_i && (req_i || trigger_i || overrun_i)) begin
        log_error("activity on idle line after reset");
      end
      if (trig_check_i && (trigger_i !== (frames_sent_i >= BP_TRIG_CHARS))) begin
        log_error($sformatf("trigger_o is %b after %0d frames", trigger_i, frames_sent_i));
      end
      if (final_check_i) begin
        if (rx_cnt != NR_EXPECTED) begin
          log_error($sformatf("%0d characters, expected %0d", rx_cnt, NR_EXPECTED));
        end
        if (overrun_cnt != NR_OVERRUNS) begin
          log_error($sformatf("%0d overrun pulses, expected %0d", overrun_cnt, NR_OVERRUNS));
        end
      end
    end
    req_q  <= req_i;
    ack_q  <= ack_i;
    char_q <= char_i;
  end

  assign err_cnt_o = err_cnt;
  assign rx_cnt_o  = rx_cnt;

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
  parameter int unsigned OVERSAMPLE = 16,
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  oversample_tick_i,
  input  logic                  rxd_i,
  input  uart_rx_pkg::rx_cfg_t  cfg_i,
  input  logic                  ack_i,
  output logic                  req_o,
  output uart_rx_pkg::rx_char_t char_o,
  output logic                  trigger_o,
  output logic                  overrun_o
);

  localparam int unsigned USAGE_W = $clog2(FIFO_DEPTH + 1);

  // ----------------------------------------------------------------------
  // Interconnect
  // ----------------------------------------------------------------------
  logic                  sync_rxd;
  logic                  bit_center;
  logic                  sample;
  logic                  timing_clear;
  logic                  timing_load;
  logic                  push;
  uart_rx_pkg::rx_char_t frame_char;
  uart_rx_pkg::rx_char_t head_char;
  logic                  fifo_empty;
  logic                  fifo_pop;
  logic [USAGE_W-1:0]    fifo_usage;

  // Input stages and bit timing
  uart_rx_sampler #(
    .OVERSAMPLE (OVERSAMPLE)
  ) i_sampler (
    .clk_i,
    .rst_n_i,
    .oversample_tick_i,
    .rxd_i,
    .timing_clear_i (timing_clear),
    .timing_load_i  (timing_load),
    .sync_rxd_o     (sync_rxd),
    .bit_center_o   (bit_center),
    .sample_o       (sample)
  );

  // Frame FSM
  uart_rx_frame i_frame (
    .clk_i,
    .rst_n_i,
    .cfg_i,
    .sync_rxd_i     (sync_rxd),
    .bit_center_i   (bit_center),
    .sample_i       (sample),
    .timing_clear_o (timing_clear),
    .timing_load_o  (timing_load),
    .push_o         (push),
    .char_o         (frame_char)
  );

  // Receive FIFO, full only matters inside for overrun
  uart_rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .payload_t  (uart_rx_pkg::rx_char_t)
  ) i_fifo (
    .clk_i,
    .rst_n_i,
    .push_i    (push),
    .data_i    (frame_char),
    .pop_i     (fifo_pop),
    .data_o    (head_char),
    .full_o    (),
    .empty_o   (fifo_empty),
    .usage_o   (fifo_usage),
    .overrun_o
  );

  // Handshake and trigger
  uart_rx_out #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_out (
    .clk_i,
    .rst_n_i,
    .empty_i      (fifo_empty),
    .usage_i      (fifo_usage),
    .head_i       (head_char),
    .ack_i,
    .trig_level_i (cfg_i.trig_level),
    .pop_o        (fifo_pop),
    .req_o,
    .char_o,
    .trigger_o
  );

endmodule

// ==== verilog/uart_rx_fifo.sv ====
`timescale 1ns/1ps

module uart_rx_fifo #(
  parameter int unsigned FIFO_DEPTH = 16,
  parameter type         payload_t  = logic [7:0]
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             push_i,
  input  payload_t                         data_i,
  input  logic                             pop_i,
  output payload_t                         data_o,
  output logic                             full_o,
  output logic                             empty_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]  usage_o,
  output logic                             overrun_o
);

  localparam int unsigned      PTR_W   = $clog2(FIFO_DEPTH);
  localparam int unsigned      USAGE_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST    = PTR_W'(FIFO_DEPTH - 1);

  payload_t           mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [USAGE_W-1:0] count_q;
  logic               do_push;
  logic               do_pop;
  logic               overrun_q;

  assign full_o  = (count_q == USAGE_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;   // Dropped when full
  assign do_pop  = pop_i && !empty_o;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      overrun_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
      overrun_q <= push_i && full_o;  // One-cycle pulse
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  assign data_o    = mem[rd_ptr_q];  // Head of queue
  assign usage_o   = count_q;
  assign overrun_o = overrun_q;

endmodule

// ==== verilog/uart_rx_frame.sv ====
`timescale 1ns/1ps

module uart_rx_frame (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  uart_rx_pkg::rx_cfg_t  cfg_i,
  input  logic                  sync_rxd_i,
  input  logic                  bit_center_i,
  input  logic                  sample_i,
  output logic                  timing_clear_o,
  output logic                  timing_load_o,
  output logic                  push_o,
  output uart_rx_pkg::rx_char_t char_o
);

  uart_rx_pkg::rx_state_e state_q, state_d;
  uart_rx_pkg::rx_char_t  char_q;
  logic [2:0] bit_cnt_q;
  logic [2:0] last_bit;     // Index of the final data bit
  logic [7:0] rsr_q;        // Receive shift register
  logic       par_err_q;
  logic       seen_high_q;  // Any data or parity bit was 1
  logic       push_q;
  logic       data_par;
  logic       par_err_calc;

  assign last_bit = {1'b1, cfg_i.word_len};  // 4..7

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      uart_rx_pkg::IDLE: begin
        if (!sync_rxd_i) state_d = uart_rx_pkg::START;
      end
      uart_rx_pkg::START: begin
        if (bit_center_i) begin
          // Glitch if start bit is high at its center
          state_d = sample_i ? uart_rx_pkg::IDLE : uart_rx_pkg::DATA;
        end
      end
      uart_rx_pkg::DATA: begin
        if (bit_center_i && (bit_cnt_q == last_bit)) begin
          state_d = cfg_i.par_en ? uart_rx_pkg::PAR : uart_rx_pkg::STOP;
        end
      end
      uart_rx_pkg::PAR: begin
        if (bit_center_i) state_d = uart_rx_pkg::STOP;
      end
      uart_rx_pkg::STOP: begin
        if (bit_center_i) begin
          state_d = sample_i ? uart_rx_pkg::IDLE : uart_rx_pkg::RESYNC;
        end
      end
      uart_rx_pkg::RESYNC: begin
        state_d = sync_rxd_i ? uart_rx_pkg::IDLE : uart_rx_pkg::START;  // Line still low
      end
      default: state_d = uart_rx_pkg::IDLE;
    endcase
  end

  assign timing_clear_o = (state_q == uart_rx_pkg::IDLE);
  assign timing_load_o  = (state_q == uart_rx_pkg::IDLE) && !sync_rxd_i;

  // Parity check against the received data bits
  always_comb begin
    data_par = ^rsr_q;  // High bits are zero for short words
    unique case (cfg_i.par_mode)
      uart_rx_pkg::PAR_ODD:  par_err_calc = (data_par == sample_i);
      uart_rx_pkg::PAR_EVEN: par_err_calc = (data_par != sample_i);
      uart_rx_pkg::PAR_ONE:  par_err_calc = !sample_i;
      default:               par_err_calc = sample_i;  // Forced 0
    endcase
  end

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= uart_rx_pkg::IDLE;
      bit_cnt_q <= '0;
      push_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      push_q  <= (state_q == uart_rx_pkg::STOP) && bit_center_i;  // Once per frame
      if (state_q == uart_rx_pkg::START) begin
        bit_cnt_q <= '0;
      end else if ((state_q == uart_rx_pkg::DATA) && bit_center_i) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // Shift register and per-frame flags
  always_ff @(posedge clk_i) begin
    if ((state_q == uart_rx_pkg::START) && bit_center_i) begin
      rsr_q       <= '0;
      par_err_q   <= 1'b0;
      seen_high_q <= 1'b0;
    end else if ((state_q == uart_rx_pkg::DATA) && bit_center_i) begin
      rsr_q[bit_cnt_q] <= sample_i;  // LSB first
      seen_high_q      <= seen_high_q | sample_i;
    end else if ((state_q == uart_rx_pkg::PAR) && bit_center_i) begin
      par_err_q   <= par_err_calc;
      seen_high_q <= seen_high_q | sample_i;
    end
    if ((state_q == uart_rx_pkg::STOP) && bit_center_i) begin
      char_q.par_err   <= par_err_q;
      char_q.frame_err <= !sample_i;
      char_q.brk       <= !seen_high_q && !sample_i;  // All-zero frame
      char_q.data      <= rsr_q;
    end
  end

  assign push_o = push_q;
  assign char_o = char_q;

endmodule

// ==== verilog/uart_rx_out.sv ====
`timescale 1ns/1ps

module uart_rx_out #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             empty_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]  usage_i,
  input  uart_rx_pkg::rx_char_t            head_i,
  input  logic                             ack_i,
  input  uart_rx_pkg::trig_level_e         trig_level_i,
  output logic                             pop_o,
  output logic                             req_o,
  output uart_rx_pkg::rx_char_t            char_o,
  output logic                             trigger_o
);

  localparam int unsigned USAGE_W = $clog2(FIFO_DEPTH + 1);

  logic                  req_q;   // Low: waiting, high: offering a character
  uart_rx_pkg::rx_char_t char_q;

  // ----------------------------------------------------------------------
  // Four-phase req/ack
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (!req_q) begin
      if (!empty_i && !ack_i) req_q <= 1'b1;  // Previous ack must be gone
    end else if (ack_i) begin
      req_q <= 1'b0;
    end
  end

  // Capture head as req rises, held until the next rise
  always_ff @(posedge clk_i) begin
    if (!req_q && !empty_i && !ack_i) char_q <= head_i;
  end

  assign pop_o  = req_q && ack_i;  // One cycle, req drops next
  assign req_o  = req_q;
  assign char_o = char_q;

  // Trigger level reached
  assign trigger_o = (usage_i >= USAGE_W'(uart_rx_pkg::TRIG_CHARS[trig_level_i]));

endmodule

// ==== verilog/uart_rx_pkg.sv ====
package uart_rx_pkg;

  // ----------------------------------------------------------------------
  // Constants
  // ----------------------------------------------------------------------
  localparam int unsigned NR_SYNC_STAGES = 2;  // Input synchronizer depth

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    PAR_ODD  = 2'b00,  // Odd number of ones incl. parity bit
    PAR_EVEN = 2'b01,
    PAR_ONE  = 2'b10,  // Forced 1
    PAR_ZERO = 2'b11   // Forced 0
  } parity_mode_e;

  typedef enum logic [1:0] {
    TRIG_1  = 2'b00,
    TRIG_4  = 2'b01,
    TRIG_8  = 2'b10,
    TRIG_14 = 2'b11
  } trig_level_e;

  // Characters per trigger level, indexed by trig_level_e
  localparam logic [4:0] TRIG_CHARS [4] = '{5'd1, 5'd4, 5'd8, 5'd14};

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PAR,
    STOP,
    RESYNC  // After a framing error
  } rx_state_e;

  // ----------------------------------------------------------------------
  // Structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [1:0]   word_len;    // 0: 5 bits ... 3: 8 bits
    logic         par_en;
    parity_mode_e par_mode;
    trig_level_e  trig_level;
  } rx_cfg_t;

  typedef struct packed {
    logic       par_err;
    logic       frame_err;
    logic       brk;        // Break condition
    logic [7:0] data;       // Zero-extended for short words
  } rx_char_t;

endpackage

// ==== verilog/uart_rx_sampler.sv ====
`timescale 1ns/1ps

module uart_rx_sampler #(
  parameter int unsigned OVERSAMPLE = 16
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic oversample_tick_i,
  input  logic rxd_i,
  input  logic timing_clear_i,    // Hold count at 0
  input  logic timing_load_i,     // Start edge seen
  output logic sync_rxd_o,
  output logic bit_center_o,
  output logic sample_o
);

  localparam int unsigned      CNT_W     = $clog2(OVERSAMPLE);
  localparam logic [CNT_W-1:0] WRAP_CNT  = CNT_W'(OVERSAMPLE - 1);
  localparam logic [CNT_W-1:0] LOAD_CNT  = CNT_W'(2);  // Edge shared a tick
  // Tick arriving at these counts: 5 resets, 6..8 sample (for 16x)
  localparam logic [CNT_W-1:0] INIT_CNT  = CNT_W'(OVERSAMPLE / 2 - 4);
  localparam logic [CNT_W-1:0] FIRST_CNT = CNT_W'(OVERSAMPLE / 2 - 3);
  localparam logic [CNT_W-1:0] LAST_CNT  = CNT_W'(OVERSAMPLE / 2 - 1);

  logic [uart_rx_pkg::NR_SYNC_STAGES-1:0] sync_q;
  logic [CNT_W-1:0] cnt_q;
  logic [1:0]       high_cnt_q;    // High samples seen around center
  logic             bit_center_q;
  logic             maj_init;
  logic             maj_sample;

  // ----------------------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '1;  // Idle line is high
    end else begin
      sync_q <= {sync_q[uart_rx_pkg::NR_SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign sync_rxd_o = sync_q[uart_rx_pkg::NR_SYNC_STAGES-1];

  // ----------------------------------------------------------------------
  // Bit timing counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (timing_load_i && oversample_tick_i) begin
      cnt_q <= LOAD_CNT;  // Tick lost to the edge cycle
    end else if (timing_clear_i) begin
      cnt_q <= '0;
    end else if (oversample_tick_i) begin
      cnt_q <= (cnt_q == WRAP_CNT) ? '0 : cnt_q + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Majority filter
  // ----------------------------------------------------------------------
  assign maj_init   = oversample_tick_i && (cnt_q == INIT_CNT);
  assign maj_sample = oversample_tick_i && (cnt_q >= FIRST_CNT) && (cnt_q <= LAST_CNT);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      high_cnt_q   <= '0;
      bit_center_q <= 1'b0;
    end else begin
      if (maj_init) begin
        high_cnt_q <= '0;
      end else if (maj_sample) begin
        high_cnt_q <= high_cnt_q + {1'b0, sync_rxd_o};  // At most 3
      end
      // Pulse once the third sample is in
      bit_center_q <= oversample_tick_i && (cnt_q == LAST_CNT);
    end
  end

  assign bit_center_o = bit_center_q;
  assign sample_o     = high_cnt_q[1];  // Two or three highs

endmodule
